/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_idu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh tb/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+hw
+incdir+tb
hw/rv_idu_pkg.sv
hw/rv_imm_gen.sv
hw/rv_ctrl_decode.sv
hw/rv_idu.sv
tb/tb_rv_idu.sv

/* hw/rv_ctrl_decode.sv */
`timescale 1ns/1ps
`include "rv_idu_settings.svh"

module rv_ctrl_decode (
  input  logic [`RV_XLEN-1:0]    i_inst,
  output rv_idu_pkg::alu_op_e    o_alu_op,
  output rv_idu_pkg::src1_sel_e  o_src1_sel,
  output rv_idu_pkg::src2_sel_e  o_src2_sel,
  output logic                   o_mem_en,
  output logic                   o_mem_we,
  output rv_idu_pkg::mem_width_e o_mem_width,
  output logic                   o_mem_unsigned,
  output logic                   o_reg_wen,
  output logic                   o_mem_to_reg,
  output logic                   o_jump,
  output logic                   o_jalr,
  output logic                   o_branch,
  output logic                   o_ecall,
  output logic                   o_ebreak,
  output logic                   o_mret,
  output logic                   o_csr_we,
  output rv_idu_pkg::csr_op_e    o_csr_op,
  output rv_idu_pkg::imm_fmt_e   o_imm_fmt,
  output logic                   o_illegal
);
  import rv_idu_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_CSR_AW-1:0] sys_imm;
  logic                  rd_nz;

  assign opcode  = opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign sys_imm = i_inst[31:20];
  assign rd_nz   = |i_inst[11:7];  // CSR read to x0 writes nothing

  // Register-register and register-immediate ALU ops share one table
  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'd0:    op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLT;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Illegal encodings of each opcode
  always_comb begin
    o_illegal = 1'b0;
    case (opcode)
      OPC_LOAD:   o_illegal = funct3 inside {3'd3, 3'd6, 3'd7};
      OPC_STORE:  o_illegal = funct3 > 3'd2;
      OPC_BRANCH: o_illegal = funct3 inside {3'd2, 3'd3};
      OPC_OP: begin
        o_illegal = !((funct7 == `RV_FUNCT7_STD) ||
                      ((funct7 == `RV_FUNCT7_ALT) && (funct3 inside {3'd0, 3'd5})));
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'd0: begin
            o_illegal = !(sys_imm inside {`RV_SYS_ECALL, `RV_SYS_EBREAK, `RV_SYS_MRET});
          end
          3'd1,
          3'd2:    o_illegal = 1'b0;  // CSRRW, CSRRS
          default: o_illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM,
      OPC_AUIPC,
      OPC_LUI,
      OPC_JAL,
      OPC_JALR:   o_illegal = 1'b0;
      default:    o_illegal = 1'b1;
    endcase
  end

  always_comb begin
    // Neutral defaults that each opcode overrides
    o_alu_op       = ALU_ADD;
    o_src1_sel     = SRC1_REG;
    o_src2_sel     = SRC2_REG;
    o_mem_en       = 1'b0;
    o_mem_we       = 1'b0;
    o_mem_width    = MEM_WORD;
    o_mem_unsigned = 1'b0;
    o_reg_wen      = 1'b0;
    o_mem_to_reg   = 1'b0;
    o_jump         = 1'b0;
    o_jalr         = 1'b0;
    o_branch       = 1'b0;
    o_ecall        = 1'b0;
    o_ebreak       = 1'b0;
    o_mret         = 1'b0;
    o_csr_we       = 1'b0;
    o_csr_op       = CSR_NONE;
    o_imm_fmt      = IMM_NONE;

    if (!o_illegal) begin
      case (opcode)
        OPC_LOAD: begin
          o_mem_en       = 1'b1;
          o_reg_wen      = 1'b1;
          o_mem_to_reg   = 1'b1;
          o_src2_sel     = SRC2_IMM;
          o_mem_width    = mem_width_e'(funct3[1:0]);
          o_mem_unsigned = funct3[2];  // LBU, LHU
          o_imm_fmt      = IMM_I;
        end
        OPC_STORE: begin
          o_mem_en    = 1'b1;
          o_mem_we    = 1'b1;
          o_src2_sel  = SRC2_IMM;
          o_mem_width = mem_width_e'(funct3[1:0]);
          o_imm_fmt   = IMM_S;
        end
        OPC_OP_IMM: begin
          o_reg_wen  = 1'b1;
          o_src2_sel = SRC2_IMM;
          o_alu_op   = alu_of(funct3, (funct3 == 3'd5) && i_inst[30]);  // No SUBI
          o_imm_fmt  = IMM_I;
        end
        OPC_OP: begin
          o_reg_wen = 1'b1;
          o_alu_op  = alu_of(funct3, i_inst[30]);
        end
        OPC_BRANCH: begin
          o_branch  = 1'b1;
          o_imm_fmt = IMM_B;
          case (funct3[2:1])
            2'b10:   o_alu_op = ALU_SLT;   // BLT, BGE
            2'b11:   o_alu_op = ALU_SLTU;  // BLTU, BGEU
            default: o_alu_op = ALU_SUB;   // BEQ, BNE
          endcase
        end
        OPC_JAL: begin
          o_reg_wen  = 1'b1;
          o_jump     = 1'b1;
          o_src1_sel = SRC1_PC;
          o_src2_sel = SRC2_IMM;
          o_imm_fmt  = IMM_J;
        end
        OPC_JALR: begin
          o_reg_wen  = 1'b1;
          o_jump     = 1'b1;
          o_jalr     = 1'b1;
          o_src2_sel = SRC2_IMM;
          o_imm_fmt  = IMM_I;
        end
        OPC_AUIPC: begin
          o_reg_wen  = 1'b1;
          o_src1_sel = SRC1_PC;
          o_src2_sel = SRC2_IMM;
          o_imm_fmt  = IMM_U;
        end
        OPC_LUI: begin
          o_reg_wen  = 1'b1;
          o_alu_op   = ALU_LUI;
          o_src1_sel = SRC1_ZERO;
          o_src2_sel = SRC2_IMM;
          o_imm_fmt  = IMM_U;
        end
        OPC_SYSTEM: begin
          case (funct3)
            3'd0: begin
              o_ecall  = (sys_imm == `RV_SYS_ECALL);
              o_ebreak = (sys_imm == `RV_SYS_EBREAK);
              o_mret   = (sys_imm == `RV_SYS_MRET);
            end
            3'd1: begin
              o_csr_we  = 1'b1;
              o_csr_op  = CSR_RW;
              o_reg_wen = rd_nz;
            end
            default: begin
              o_csr_we  = 1'b1;
              o_csr_op  = CSR_RS;
              o_reg_wen = rd_nz;
            end
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

/* hw/rv_idu.sv */
`timescale 1ns/1ps
`include "rv_idu_settings.svh"

module rv_idu (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_valid,
  input  logic [`RV_XLEN-1:0]    i_inst,
  output logic                   o_valid,
  output logic [`RV_REG_AW-1:0]  o_rs1_addr,
  output logic [`RV_REG_AW-1:0]  o_rs2_addr,
  output logic [`RV_REG_AW-1:0]  o_rd_addr,
  output logic [2:0]             o_funct3,
  output logic [`RV_CSR_AW-1:0]  o_csr_addr,
  output logic [`RV_XLEN-1:0]    o_imm,
  output rv_idu_pkg::alu_op_e    o_alu_op,
  output rv_idu_pkg::src1_sel_e  o_src1_sel,
  output rv_idu_pkg::src2_sel_e  o_src2_sel,
  output logic                   o_mem_en,
  output logic                   o_mem_we,
  output rv_idu_pkg::mem_width_e o_mem_width,
  output logic                   o_mem_unsigned,
  output logic                   o_reg_wen,
  output logic                   o_mem_to_reg,
  output logic                   o_jump,
  output logic                   o_jalr,
  output logic                   o_branch,
  output logic                   o_ecall,
  output logic                   o_ebreak,
  output logic                   o_mret,
  output logic                   o_csr_we,
  output rv_idu_pkg::csr_op_e    o_csr_op,
  output logic                   o_illegal
);
  import rv_idu_pkg::*;

  alu_op_e             dec_alu_op;
  src1_sel_e           dec_src1_sel;
  src2_sel_e           dec_src2_sel;
  mem_width_e          dec_mem_width;
  csr_op_e             dec_csr_op;
  imm_fmt_e            imm_fmt;
  logic [`RV_XLEN-1:0] imm;
  logic                dec_mem_en;
  logic                dec_mem_we;
  logic                dec_mem_unsigned;
  logic                dec_reg_wen;
  logic                dec_mem_to_reg;
  logic                dec_jump;
  logic                dec_jalr;
  logic                dec_branch;
  logic                dec_ecall;
  logic                dec_ebreak;
  logic                dec_mret;
  logic                dec_csr_we;
  logic                dec_illegal;

  rv_ctrl_decode u_ctrl_decode (
    .i_inst        (i_inst),
    .o_alu_op      (dec_alu_op),
    .o_src1_sel    (dec_src1_sel),
    .o_src2_sel    (dec_src2_sel),
    .o_mem_en      (dec_mem_en),
    .o_mem_we      (dec_mem_we),
    .o_mem_width   (dec_mem_width),
    .o_mem_unsigned(dec_mem_unsigned),
    .o_reg_wen     (dec_reg_wen),
    .o_mem_to_reg  (dec_mem_to_reg),
    .o_jump        (dec_jump),
    .o_jalr        (dec_jalr),
    .o_branch      (dec_branch),
    .o_ecall       (dec_ecall),
    .o_ebreak      (dec_ebreak),
    .o_mret        (dec_mret),
    .o_csr_we      (dec_csr_we),
    .o_csr_op      (dec_csr_op),
    .o_imm_fmt     (imm_fmt),
    .o_illegal     (dec_illegal)
  );

  rv_imm_gen u_imm_gen (
    .i_inst(i_inst),
    .i_fmt (imm_fmt),
    .o_imm (imm)
  );

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid        <= 1'b0;
      o_imm          <= '0;
      o_alu_op       <= ALU_ADD;
      o_src1_sel     <= SRC1_REG;
      o_src2_sel     <= SRC2_REG;
      o_mem_en       <= 1'b0;
      o_mem_we       <= 1'b0;
      o_mem_width    <= MEM_WORD;
      o_mem_unsigned <= 1'b0;
      o_reg_wen      <= 1'b0;
      o_mem_to_reg   <= 1'b0;
      o_jump         <= 1'b0;
      o_jalr         <= 1'b0;
      o_branch       <= 1'b0;
      o_ecall        <= 1'b0;
      o_ebreak       <= 1'b0;
      o_mret         <= 1'b0;
      o_csr_we       <= 1'b0;
      o_csr_op       <= CSR_NONE;
      o_illegal      <= 1'b0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin  // Hold last decode on idle cycles
        o_imm          <= imm;
        o_alu_op       <= dec_alu_op;
        o_src1_sel     <= dec_src1_sel;
        o_src2_sel     <= dec_src2_sel;
        o_mem_en       <= dec_mem_en;
        o_mem_we       <= dec_mem_we;
        o_mem_width    <= dec_mem_width;
        o_mem_unsigned <= dec_mem_unsigned;
        o_reg_wen      <= dec_reg_wen;
        o_mem_to_reg   <= dec_mem_to_reg;
        o_jump         <= dec_jump;
        o_jalr         <= dec_jalr;
        o_branch       <= dec_branch;
        o_ecall        <= dec_ecall;
        o_ebreak       <= dec_ebreak;
        o_mret         <= dec_mret;
        o_csr_we       <= dec_csr_we;
        o_csr_op       <= dec_csr_op;
        o_illegal      <= dec_illegal;
      end
    end
  end

  // Raw instruction fields
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rs1_addr <= i_inst[19:15];
      o_rs2_addr <= i_inst[24:20];
      o_rd_addr  <= i_inst[11:7];
      o_funct3   <= i_inst[14:12];
      o_csr_addr <= i_inst[31:20];
    end
  end

  a_we_needs_en: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_mem_we |-> o_mem_en);

  a_one_flow_change: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $onehot0({o_jump, o_branch, o_ecall, o_ebreak, o_mret}));

  a_illegal_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_illegal |-> !(o_reg_wen || o_mem_en || o_csr_we));

endmodule

/* hw/rv_idu_pkg.sv */
package rv_idu_pkg;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10  // Passes operand 2 through
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC1_REG  = 2'b00,
    SRC1_PC   = 2'b01,
    SRC1_ZERO = 2'b10
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_REG  = 2'b00,
    SRC2_IMM  = 2'b01,
    SRC2_FOUR = 2'b10
  } src2_sel_e;

  // Same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_width_e;

  typedef enum logic [1:0] {
    CSR_NONE = 2'b00,
    CSR_RW   = 2'b01,
    CSR_RS   = 2'b10
  } csr_op_e;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_e;

endpackage

/* hw/rv_idu_settings.svh */
`ifndef RV_IDU_SETTINGS_SVH
`define RV_IDU_SETTINGS_SVH

// Datapath and field widths
`define RV_XLEN   32
`define RV_REG_AW 5
`define RV_CSR_AW 12

// funct7 of base and alternate (SUB, SRA) forms
`define RV_FUNCT7_STD 7'h00
`define RV_FUNCT7_ALT 7'h20

// inst[31:20] of the privileged system instructions
`define RV_SYS_ECALL  12'h000
`define RV_SYS_EBREAK 12'h001
`define RV_SYS_MRET   12'h302

`endif

/* hw/rv_imm_gen.sv */
`timescale 1ns/1ps
`include "rv_idu_settings.svh"

module rv_imm_gen (
  input  logic [`RV_XLEN-1:0] i_inst,
  input  rv_idu_pkg::imm_fmt_e i_fmt,
  output logic [`RV_XLEN-1:0] o_imm
);
  import rv_idu_pkg::*;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};  // No extension needed
  assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      IMM_I:   o_imm = imm_i;
      IMM_S:   o_imm = imm_s;
      IMM_B:   o_imm = imm_b;
      IMM_U:   o_imm = imm_u;
      IMM_J:   o_imm = imm_j;
      default: o_imm = '0;  // R-type, system, illegal
    endcase
  end

endmodule

/* tb/tb_rv_idu_model.svh */
`ifndef TB_RV_IDU_MODEL_SVH
`define TB_RV_IDU_MODEL_SVH

`include "rv_idu_settings.svh"

// Same field order as the DUT control outputs, imm last
typedef struct packed {
  logic                illegal;
  alu_op_e             alu_op;
  src1_sel_e           src1_sel;
  src2_sel_e           src2_sel;
  logic                mem_en, mem_we;
  mem_width_e          mem_width;
  logic                mem_unsigned, reg_wen, mem_to_reg, jump, jalr, branch;
  logic                ecall, ebreak, mret, csr_we;
  csr_op_e             csr_op;
  logic [`RV_XLEN-1:0] imm;
} ctrl_t;

typedef struct packed {
  logic [`RV_REG_AW-1:0] rs1, rs2, rd;
  logic [2:0]            funct3;
  logic [`RV_CSR_AW-1:0] csr;
} fld_t;

function automatic ctrl_t neutral_ctrl();
  ctrl_t c;
  c           = '0;  // Disabled, ADD, REG/REG, zero imm
  c.mem_width = MEM_WORD;
  return c;
endfunction

function automatic alu_op_e alu_from(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return alt ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic ctrl_t expect_decode(input logic [`RV_XLEN-1:0] inst);
  ctrl_t               c;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  c     = neutral_ctrl();
  f3    = inst[14:12];
  f7    = inst[31:25];
  imm_i = $signed(inst) >>> 20;
  imm_s = {imm_i[31:5], inst[11:7]};
  case (inst[6:0])
    OPC_LOAD, OPC_STORE: begin
      c.illegal      = (inst[6:0] == OPC_LOAD) ? ((f3 == 3'd3) || (f3 > 3'd5)) : (f3 > 3'd2);
      c.mem_en       = 1'b1;
      c.mem_we       = (inst[6:0] == OPC_STORE);
      c.reg_wen      = !c.mem_we;
      c.mem_to_reg   = !c.mem_we;
      c.src2_sel     = SRC2_IMM;
      c.mem_width    = (f3[1:0] == 2'd0) ? MEM_BYTE : (f3[1:0] == 2'd1) ? MEM_HALF : MEM_WORD;
      c.mem_unsigned = f3[2] && !c.mem_we;
      c.imm          = c.mem_we ? imm_s : imm_i;
    end
    OPC_OP_IMM: begin
      c.reg_wen  = 1'b1;
      c.src2_sel = SRC2_IMM;
      c.alu_op   = alu_from(f3, (f3 == 3'd5) && inst[30]);
      c.imm      = imm_i;
    end
    OPC_OP: begin
      c.illegal = !((f7 == `RV_FUNCT7_STD) ||
                    ((f7 == `RV_FUNCT7_ALT) && ((f3 == 3'd0) || (f3 == 3'd5))));
      c.reg_wen = 1'b1;
      c.alu_op  = alu_from(f3, f7 == `RV_FUNCT7_ALT);
    end
    OPC_BRANCH: begin
      c.illegal = (f3 == 3'd2) || (f3 == 3'd3);
      c.branch  = 1'b1;
      c.alu_op  = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
      c.imm     = {imm_s[31:12], inst[7], imm_s[10:1], 1'b0};
    end
    OPC_JAL, OPC_JALR: begin
      c.reg_wen  = 1'b1;
      c.jump     = 1'b1;
      c.jalr     = (inst[6:0] == OPC_JALR);
      c.src1_sel = c.jalr ? SRC1_REG : SRC1_PC;
      c.src2_sel = SRC2_IMM;
      c.imm      = c.jalr ? imm_i : {imm_i[31:20], inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    OPC_AUIPC, OPC_LUI: begin
      c.reg_wen  = 1'b1;
      c.alu_op   = (inst[6:0] == OPC_LUI) ? ALU_LUI : ALU_ADD;
      c.src1_sel = (inst[6:0] == OPC_LUI) ? SRC1_ZERO : SRC1_PC;
      c.src2_sel = SRC2_IMM;
      c.imm      = inst & 32'hffff_f000;
    end
    OPC_SYSTEM: begin
      c.ecall   = (f3 == 3'd0) && (inst[31:20] == `RV_SYS_ECALL);
      c.ebreak  = (f3 == 3'd0) && (inst[31:20] == `RV_SYS_EBREAK);
      c.mret    = (f3 == 3'd0) && (inst[31:20] == `RV_SYS_MRET);
      c.csr_we  = (f3 == 3'd1) || (f3 == 3'd2);
      c.csr_op  = (f3 == 3'd1) ? CSR_RW : (f3 == 3'd2) ? CSR_RS : CSR_NONE;
      c.reg_wen = c.csr_we && (inst[11:7] != 5'd0);  // rd x0 skips the write
      c.illegal = !(c.ecall || c.ebreak || c.mret || c.csr_we);
    end
    default: c.illegal = 1'b1;
  endcase
  if (c.illegal) begin
    c         = neutral_ctrl();
    c.illegal = 1'b1;
  end
  return c;
endfunction

function automatic fld_t fields_of(input logic [`RV_XLEN-1:0] inst);
  return {inst[19:15], inst[24:20], inst[11:7], inst[14:12], inst[31:20]};
endfunction

function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] itype_inst(input logic [11:0] imm, input logic [4:0] rs1,
    input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] stype_inst(input logic [11:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] btype_inst(input logic [12:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] jtype_inst(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

/* tb/tb_rv_idu.sv */
`timescale 1ns/1ps
`include "rv_idu_settings.svh"

module tb_rv_idu;
  import rv_idu_pkg::*;

  `include "tb_rv_idu_model.svh"

  localparam int N_RAND      = 2000;
  localparam int CYCLE_LIMIT = 3000;  // ~100 directed, 2000 random, 1 in 8 gaps

  logic                  i_clk, i_arst_n, i_valid;
  logic [`RV_XLEN-1:0]   i_inst;
  logic                  o_valid;
  logic [`RV_REG_AW-1:0] o_rs1_addr, o_rs2_addr, o_rd_addr;
  logic [2:0]            o_funct3;
  logic [`RV_CSR_AW-1:0] o_csr_addr;
  logic [`RV_XLEN-1:0]   o_imm;
  alu_op_e               o_alu_op;
  src1_sel_e             o_src1_sel;
  src2_sel_e             o_src2_sel;
  mem_width_e            o_mem_width;
  csr_op_e               o_csr_op;
  logic                  o_mem_en, o_mem_we, o_mem_unsigned, o_reg_wen, o_mem_to_reg;
  logic                  o_jump, o_jalr, o_branch, o_ecall, o_ebreak, o_mret;
  logic                  o_csr_we, o_illegal;

  logic [31:0] rnd, prev_inst, last_inst;
  logic        prev_valid, have_inst;
  ctrl_t       last_exp, got;
  int          cycles = 0;

  rv_idu i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic stop_on_error(input string what);
    $display("ERR %0t: %s", $time, what);
    $display("Done: errors found");
    $fatal(1, "decode check failed");
  endtask

  task automatic send_inst(input logic [31:0] w);
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_inst  <= w;
  endtask

  task automatic idle_cycle();
    @(posedge i_clk);
    rnd = xorshift32(rnd);
    i_valid <= 1'b0;
    i_inst  <= rnd;  // Junk on the bus must not leak through
  endtask

  function automatic logic [6:0] pick_opcode(input logic [3:0] sel, input logic [6:0] raw);
    case (sel)
      4'd0, 4'd10: return OPC_LOAD;
      4'd1:        return OPC_STORE;
      4'd2, 4'd11: return OPC_OP_IMM;
      4'd3, 4'd12: return OPC_OP;
      4'd4:        return OPC_BRANCH;
      4'd5:        return OPC_JAL;
      4'd6:        return OPC_JALR;
      4'd7:        return OPC_LUI;
      4'd8:        return OPC_AUIPC;
      4'd9:        return OPC_SYSTEM;
      default:     return raw;  // Mostly unknown opcodes
    endcase
  endfunction

  task automatic run_directed();
    for (int f = 0; f < 8; f++) begin
      send_inst(itype_inst(12'(12'h801 + f), 5'(f), 3'(f), 5'(f + 9), OPC_LOAD));
      send_inst(stype_inst(12'(12'h7f0 - 3 * f), 5'(f + 2), 5'(f + 3), 3'(f)));
      send_inst(btype_inst(13'(13'h1ff4 + 2 * f), 5'(f), 5'(31 - f), 3'(f)));
      send_inst(itype_inst((f == 5) ? 12'h40b : 12'(12'h9a3 + f), 5'd3, 3'(f), 5'd4, OPC_OP_IMM));
      send_inst(rtype_inst(`RV_FUNCT7_STD, 5'(f + 4), 5'd6, 3'(f), 5'd7, OPC_OP));
      send_inst(rtype_inst(`RV_FUNCT7_ALT, 5'(f + 8), 5'd9, 3'(f), 5'd10, OPC_OP));
      send_inst(rtype_inst(7'h01, 5'd1, 5'd2, 3'(f), 5'd3, OPC_OP));  // M extension
      idle_cycle();
    end
    send_inst(itype_inst(12'h00b, 5'd3, 3'd5, 5'd4, OPC_OP_IMM));  // SRLI
    send_inst(jtype_inst(21'h1f_fffe, 5'd1));
    send_inst(jtype_inst(21'h0a_5566, 5'd0));
    send_inst(itype_inst(12'h800, 5'd1, 3'd0, 5'd0, OPC_JALR));
    send_inst(itype_inst(12'h07c, 5'd2, 3'd0, 5'd1, OPC_JALR));
    send_inst({20'hfedcb, 5'd5, OPC_LUI});
    send_inst({20'h12345, 5'd6, OPC_AUIPC});
    send_inst(itype_inst(`RV_SYS_ECALL, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
    send_inst(itype_inst(`RV_SYS_EBREAK, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
    send_inst(itype_inst(`RV_SYS_MRET, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
    send_inst(itype_inst(12'h105, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));  // WFI
    send_inst(itype_inst(12'h300, 5'd7, 3'd1, 5'd5, OPC_SYSTEM));
    send_inst(itype_inst(12'h305, 5'd7, 3'd1, 5'd0, OPC_SYSTEM));
    send_inst(itype_inst(12'h341, 5'd8, 3'd2, 5'd9, OPC_SYSTEM));
    send_inst(itype_inst(12'h342, 5'd0, 3'd2, 5'd0, OPC_SYSTEM));
    for (int f = 3; f < 8; f++) begin
      send_inst(itype_inst(12'h305, 5'd1, 3'(f), 5'd2, OPC_SYSTEM));
    end
    send_inst(32'h0000_000f);  // FENCE
    send_inst(32'h0000_0000);
    send_inst(32'hffff_ffff);
    send_inst(32'h8765_432b);
    idle_cycle();
    idle_cycle();
  endtask

  task automatic run_random();
    logic [31:0] w;
    for (int k = 0; k < N_RAND; k++) begin
      rnd = xorshift32(rnd);
      if (rnd[2:0] == 3'd0) idle_cycle();
      rnd = xorshift32(rnd);
      w = {rnd[31:7], pick_opcode(rnd[3:0], rnd[6:0])};
      if ((w[6:0] == OPC_OP) && rnd[12]) w[31:25] = rnd[13] ? `RV_FUNCT7_ALT : `RV_FUNCT7_STD;
      if ((w[6:0] == OPC_SYSTEM) && rnd[14]) begin
        w[14:12] = 3'd0;
        w[31:20] = rnd[15] ? `RV_SYS_MRET : {11'd0, rnd[16]};
      end
      send_inst(w);
    end
  endtask

  // Checks the previous cycle's input, or the held decode on idle cycles
  always @(posedge i_clk) begin
    if (!i_arst_n) begin
      prev_valid = 1'b0;
      have_inst  = 1'b0;
      last_inst  = '0;
      last_exp   = neutral_ctrl();
    end else begin
      if (prev_valid) begin
        last_inst = prev_inst;
        last_exp  = expect_decode(prev_inst);
        have_inst = 1'b1;
      end
      got = ctrl_t'({o_illegal, o_alu_op, o_src1_sel, o_src2_sel, o_mem_en, o_mem_we,
                     o_mem_width, o_mem_unsigned, o_reg_wen, o_mem_to_reg, o_jump, o_jalr,
                     o_branch, o_ecall, o_ebreak, o_mret, o_csr_we, o_csr_op, o_imm});
      assert (o_valid === prev_valid) else
        stop_on_error($sformatf("o_valid is %b, expected %b", o_valid, prev_valid));
      assert (got === last_exp) else
        stop_on_error($sformatf("inst %h controls %h, expected %h", last_inst, got, last_exp));
      if (have_inst) begin
        assert ({o_rs1_addr, o_rs2_addr, o_rd_addr, o_funct3, o_csr_addr} === fields_of(last_inst))
        else stop_on_error($sformatf("inst %h fields rs1 %h rs2 %h rd %h f3 %h csr %h", last_inst,
                                     o_rs1_addr, o_rs2_addr, o_rd_addr, o_funct3, o_csr_addr));
      end
      prev_valid = i_valid;
      prev_inst  = i_inst;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: stimulus still running after %0d cycles", cycles);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin
    i_arst_n = 1'b0;
    i_valid  = 1'b0;
    i_inst   = '0;
    rnd      = 32'd82457;
    repeat (2) @(posedge i_clk);
    i_arst_n <= 1'b1;
    run_directed();
    run_random();
    repeat (2) idle_cycle();
    @(negedge i_clk);
    $display("Done: no errors");
    $finish;
  end

endmodule
